// ==== logic/decode_stage.sv ====
//////////////////////////////
// Instruction decode stage
// Control decode, immediates,
// load-use stall, ID/EX register
//////////////////////////////

`timescale 1ns/1ps

module decode_stage (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_en,
    input  rv_pkg::instr_t                i_instr,
    input  logic                          i_valid,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_ex_rd,
    input  logic                          i_ex_memread,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2_addr,
    output logic                          o_stall,
    output rv_pkg::alu_op_t               o_alu_op,
    output logic                          o_alu_src,
    output logic                          o_memread,
    output logic                          o_memwrite,
    output logic                          o_regwrite,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_ex_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_ex_rs2,
    output logic [rv_pkg::XLEN-1:0]       o_a,
    output logic [rv_pkg::XLEN-1:0]       o_b,
    output logic [rv_pkg::XLEN-1:0]       o_imm
);
    import rv_pkg::*;

    alu_op_t         dec_alu_op;
    logic            dec_alu_src;
    logic            dec_memread;
    logic            dec_memwrite;
    logic            dec_regwrite;
    logic            funct_ok;
    logic [XLEN-1:0] dec_imm;
    logic            uses_rs2;
    logic            issue;

    assign o_rs1_addr = i_instr.ri.rs1;
    assign o_rs2_addr = i_instr.ri.rs2;

    // funct3 shared by R-type and I-type arithmetic
    always_comb begin
        funct_ok = 1'b1;
        case (i_instr.ri.funct3)
            3'b000: begin
                dec_alu_op = (i_instr.ri.opcode == OPC_OP && i_instr.ri.funct7[5]) ?
                             ALU_SUB : ALU_ADD;
            end
            3'b010: dec_alu_op = ALU_SLT;
            3'b100: dec_alu_op = ALU_XOR;
            3'b110: dec_alu_op = ALU_OR;
            3'b111: dec_alu_op = ALU_AND;
            default: begin
                dec_alu_op = ALU_ADD;
                funct_ok   = 1'b0;  // Shifts etc. not supported
            end
        endcase
        if (i_instr.ri.opcode == OPC_LOAD || i_instr.ri.opcode == OPC_STORE) begin
            dec_alu_op = ALU_ADD;  // Base plus offset
        end
    end

    always_comb begin
        dec_alu_src  = 1'b0;
        dec_memread  = 1'b0;
        dec_memwrite = 1'b0;
        dec_regwrite = 1'b0;
        dec_imm      = {{20{i_instr.ri.funct7[6]}}, i_instr.ri.funct7, i_instr.ri.rs2};
        case (i_instr.ri.opcode)
            OPC_OP: dec_regwrite = funct_ok;
            OPC_OP_IMM: begin
                dec_regwrite = funct_ok;
                dec_alu_src  = 1'b1;
            end
            OPC_LOAD: begin
                dec_regwrite = 1'b1;
                dec_memread  = 1'b1;
                dec_alu_src  = 1'b1;
            end
            OPC_STORE: begin
                dec_memwrite = 1'b1;
                dec_alu_src  = 1'b1;
                dec_imm      = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
            end
            default: ;
        endcase
    end

    // I-type rs2 field holds immediate bits and never stalls
    assign uses_rs2 = (i_instr.ri.opcode == OPC_OP) || (i_instr.ri.opcode == OPC_STORE);
    assign o_stall  = i_valid && i_ex_memread && (i_ex_rd != '0) &&
                      ((i_ex_rd == o_rs1_addr) || (uses_rs2 && i_ex_rd == o_rs2_addr));
    assign issue    = i_valid && !o_stall;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_alu_op   <= ALU_ADD;
            o_alu_src  <= 1'b0;
            o_memread  <= 1'b0;
            o_memwrite <= 1'b0;
            o_regwrite <= 1'b0;
        end else if (i_en) begin
            o_alu_op   <= issue ? dec_alu_op : ALU_ADD;  // Bubble on stall
            o_alu_src  <= issue && dec_alu_src;
            o_memread  <= issue && dec_memread;
            o_memwrite <= issue && dec_memwrite;
            o_regwrite <= issue && dec_regwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_rd     <= i_instr.ri.rd;
            o_ex_rs1 <= o_rs1_addr;
            o_ex_rs2 <= o_rs2_addr;
            o_a      <= i_rs1_data;
            o_b      <= i_rs2_data;
            o_imm    <= dec_imm;
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
//////////////////////////////
// Execute stage
// Operand forwarding, ALU and
// the EX/MEM register
//////////////////////////////

`timescale 1ns/1ps

module execute_stage (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_en,
    input  rv_pkg::alu_op_t               i_alu_op,
    input  logic                          i_alu_src,
    input  logic                          i_memread,
    input  logic                          i_memwrite,
    input  logic                          i_regwrite,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic [rv_pkg::XLEN-1:0]       i_a,
    input  logic [rv_pkg::XLEN-1:0]       i_b,
    input  logic [rv_pkg::XLEN-1:0]       i_imm,
    input  logic                          i_wb_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wb_data,
    output logic                          o_mem_regwrite,
    output logic                          o_mem_memread,
    output logic                          o_mem_memwrite,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_mem_rd,
    output logic [rv_pkg::XLEN-1:0]       o_mem_alu,
    output logic [rv_pkg::XLEN-1:0]       o_mem_store_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_id_ex_rd,
    output logic                          o_id_ex_memread
);
    import rv_pkg::*;

    logic [XLEN-1:0] fwd_a;
    logic [XLEN-1:0] fwd_b;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;

    // Newest producer wins: EX/MEM, then MEM/WB, then the register value
    function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] src,
                                                input logic [XLEN-1:0] reg_val);
        if (o_mem_regwrite && o_mem_rd != '0 && o_mem_rd == src) begin
            return o_mem_alu;
        end else if (i_wb_en && i_wb_rd != '0 && i_wb_rd == src) begin
            return i_wb_data;
        end
        return reg_val;
    endfunction

    always_comb begin
        fwd_a = forward(i_rs1, i_a);
        fwd_b = forward(i_rs2, i_b);
    end

    assign op_b = i_alu_src ? i_imm : fwd_b;

    always_comb begin
        case (i_alu_op)
            ALU_SUB: alu_res = fwd_a - op_b;
            ALU_AND: alu_res = fwd_a & op_b;
            ALU_OR:  alu_res = fwd_a | op_b;
            ALU_XOR: alu_res = fwd_a ^ op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
            default: alu_res = fwd_a + op_b;  // ADD and address calc
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_mem_regwrite <= 1'b0;
            o_mem_memread  <= 1'b0;
            o_mem_memwrite <= 1'b0;
        end else if (i_en) begin
            o_mem_regwrite <= i_regwrite;
            o_mem_memread  <= i_memread;
            o_mem_memwrite <= i_memwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_mem_rd         <= i_rd;
            o_mem_alu        <= alu_res;
            o_mem_store_data <= fwd_b;  // Store data needs forwarding too
        end
    end

    assign o_id_ex_rd      = i_rd;
    assign o_id_ex_memread = i_memread;

endmodule

// ==== logic/fetch_stage.sv ====
//////////////////////////////
// Instruction fetch stage
// PC, instruction memory with
// load port, IF/ID register
//////////////////////////////

`timescale 1ns/1ps

module fetch_stage (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_en,
    input  logic                           i_stall,
    input  logic                           i_imem_we,
    input  logic [rv_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  logic [rv_pkg::XLEN-1:0]        i_imem_data,
    output rv_pkg::instr_t                 o_instr,
    output logic                           o_valid
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imem [2**IMEM_ADDR_W];
    logic            advance;

    assign advance = i_en && !i_stall;

    // Unloaded words stay NOPs so a program runs off its end harmlessly
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**IMEM_ADDR_W; i++) begin
                imem[i] <= NOP_INSTR;
            end
        end else if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc      <= '0;
            o_valid <= 1'b0;
        end else if (advance) begin
            pc      <= pc + XLEN'(4);
            o_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            o_instr <= imem[pc[IMEM_ADDR_W+1:2]];  // Word index
        end
    end

endmodule

// ==== logic/mem_wb_stage.sv ====
//////////////////////////////
// Memory and writeback stage
// Data memory, MEM/WB register
// and writeback select
//////////////////////////////

`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_en,
    input  logic                          i_regwrite,
    input  logic                          i_memread,
    input  logic                          i_memwrite,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_alu,
    input  logic [rv_pkg::XLEN-1:0]       i_store_data,
    output logic                          o_wb_en,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data
);
    import rv_pkg::*;

    logic [XLEN-1:0]        dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] addr;
    logic [XLEN-1:0]        load_data;

    assign addr      = i_alu[DMEM_ADDR_W+1:2];  // Word accesses only
    assign load_data = dmem[addr];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**DMEM_ADDR_W; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_en && i_memwrite) begin
            dmem[addr] <= i_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_en <= 1'b0;
        end else if (i_en) begin
            o_wb_en <= i_regwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_wb_rd   <= i_rd;
            o_wb_data <= i_memread ? load_data : i_alu;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
//////////////////////////////
// Integer register file
// Two bypassed read ports, one
// write port, registered debug read
//////////////////////////////

`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic                          i_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic                          i_wr_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wr_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_wr_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_dbg_addr,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data,
    output logic [rv_pkg::XLEN-1:0]       o_dbg_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            we;

    assign we = i_en && i_wr_en && (i_wr_addr != '0);  // x0 never written

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write-first, so WB to ID needs no forwarding path
    assign o_rs1_data = (we && i_wr_addr == i_rs1_addr) ? i_wr_data : regs[i_rs1_addr];
    assign o_rs2_data = (we && i_wr_addr == i_rs2_addr) ? i_wr_data : regs[i_rs2_addr];

    always_ff @(posedge clk) begin
        o_dbg_data <= regs[i_dbg_addr];
    end

endmodule

// ==== logic/rv_core.sv ====
//////////////////////////////
// RV32I five-stage core top
// Connects the pipeline stages,
// the register file and the
// load and debug ports
//////////////////////////////

`timescale 1ns/1ps

module rv_core (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_en,
    input  logic                           i_imem_we,
    input  logic [rv_pkg::IMEM_ADDR_W-1:0] i_imem_addr,
    input  logic [rv_pkg::XLEN-1:0]        i_imem_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  i_dbg_addr,
    output logic [rv_pkg::XLEN-1:0]        o_dbg_data
);
    import rv_pkg::*;

    // IF/ID
    instr_t                if_instr;
    logic                  if_valid;
    logic                  stall;

    // Register file read side
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // ID/EX
    alu_op_t               ex_alu_op;
    logic                  ex_alu_src;
    logic                  ex_memread;
    logic                  ex_memwrite;
    logic                  ex_regwrite;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [REG_ADDR_W-1:0] ex_rs1;
    logic [REG_ADDR_W-1:0] ex_rs2;
    logic [XLEN-1:0]       ex_a;
    logic [XLEN-1:0]       ex_b;
    logic [XLEN-1:0]       ex_imm;
    logic [REG_ADDR_W-1:0] id_ex_rd;       // Load-use check
    logic                  id_ex_memread;

    // EX/MEM
    logic                  mem_regwrite;
    logic                  mem_memread;
    logic                  mem_memwrite;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_alu;
    logic [XLEN-1:0]       mem_store_data;

    // MEM/WB
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    fetch_stage u_fetch (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_en        (i_en),
        .i_stall     (stall),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_instr     (if_instr),
        .o_valid     (if_valid)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_en       (i_en),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wr_en    (wb_en),
        .i_wr_addr  (wb_rd),
        .i_wr_data  (wb_data),
        .i_dbg_addr (i_dbg_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_dbg_data (o_dbg_data)
    );

    decode_stage u_decode (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_en         (i_en),
        .i_instr      (if_instr),
        .i_valid      (if_valid),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_ex_rd      (id_ex_rd),
        .i_ex_memread (id_ex_memread),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .o_stall      (stall),
        .o_alu_op     (ex_alu_op),
        .o_alu_src    (ex_alu_src),
        .o_memread    (ex_memread),
        .o_memwrite   (ex_memwrite),
        .o_regwrite   (ex_regwrite),
        .o_rd         (ex_rd),
        .o_ex_rs1     (ex_rs1),
        .o_ex_rs2     (ex_rs2),
        .o_a          (ex_a),
        .o_b          (ex_b),
        .o_imm        (ex_imm)
    );

    execute_stage u_execute (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_en             (i_en),
        .i_alu_op         (ex_alu_op),
        .i_alu_src        (ex_alu_src),
        .i_memread        (ex_memread),
        .i_memwrite       (ex_memwrite),
        .i_regwrite       (ex_regwrite),
        .i_rd             (ex_rd),
        .i_rs1            (ex_rs1),
        .i_rs2            (ex_rs2),
        .i_a              (ex_a),
        .i_b              (ex_b),
        .i_imm            (ex_imm),
        .i_wb_en          (wb_en),
        .i_wb_rd          (wb_rd),
        .i_wb_data        (wb_data),
        .o_mem_regwrite   (mem_regwrite),
        .o_mem_memread    (mem_memread),
        .o_mem_memwrite   (mem_memwrite),
        .o_mem_rd         (mem_rd),
        .o_mem_alu        (mem_alu),
        .o_mem_store_data (mem_store_data),
        .o_id_ex_rd       (id_ex_rd),
        .o_id_ex_memread  (id_ex_memread)
    );

    mem_wb_stage u_mem_wb (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_en         (i_en),
        .i_regwrite   (mem_regwrite),
        .i_memread    (mem_memread),
        .i_memwrite   (mem_memwrite),
        .i_rd         (mem_rd),
        .i_alu        (mem_alu),
        .i_store_data (mem_store_data),
        .o_wb_en      (wb_en),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data)
    );

endmodule

// ==== logic/rv_pkg.sv ====
//////////////////////////////
// RV32I core shared definitions
// Widths, opcodes, ALU codes and
// the two instruction views
//////////////////////////////

package rv_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_ADDR_W = 8;   // 256 instruction words
    localparam int DMEM_ADDR_W = 5;   // 32 data words

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // ADDI x0,x0,0

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // R-type, with funct7/rs2 doubling as imm[11:5]/imm[4:0] for I-type
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_ri_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef union packed {
        instr_ri_t ri;
        instr_s_t  s;
    } instr_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f sim.f -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -qx "Verification passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1

// ==== sim.f ====
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core.sv
tests/tb_rv_core.sv

// ==== tests/tb_rv_core.sv ====
//////////////////////////////
// Testbench for the RV32I core
// Loads programs, runs them and
// checks every register against
// an in-order ISA model
//////////////////////////////

`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int MAX_CYCLES = 6000;  // Six programs with load, run and readback
    localparam int PROG_MAX   = 64;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    logic                   clk = 1'b0;
    logic                   i_rst;
    logic                   i_en;
    logic                   i_imem_we;
    logic [IMEM_ADDR_W-1:0] i_imem_addr;
    logic [XLEN-1:0]        i_imem_data;
    logic [REG_ADDR_W-1:0]  i_dbg_addr;
    logic [XLEN-1:0]        o_dbg_data;

    logic [XLEN-1:0] prog [PROG_MAX];
    int              prog_len;
    int              cycle_cnt = 0;
    integer          seed;
    event            check_start;
    event            check_done;

    rv_core i_rv_core (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_en        (i_en),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_dbg_addr  (i_dbg_addr),
        .o_dbg_data  (o_dbg_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    task automatic op_r(input logic [6:0] f7, input logic [2:0] f3, input int rd, rs1, rs2);
        prog[prog_len] = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
        prog_len++;
    endtask

    task automatic op_i(input logic [2:0] f3, input int rd, rs1, imm);
        prog[prog_len] = {12'(imm), 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
        prog_len++;
    endtask

    task automatic load_word(input int rd, rs1, imm);
        prog[prog_len] = {12'(imm), 5'(rs1), 3'b010, 5'(rd), OPC_LOAD};
        prog_len++;
    endtask

    task automatic store_word(input int rs2, rs1, imm);
        logic [11:0] off;
        off            = 12'(imm);
        prog[prog_len] = {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], OPC_STORE};
        prog_len++;
    endtask

    // ISA model: run the program in order, return one register
    function automatic logic [XLEN-1:0] model_reg(input int idx);
        logic [XLEN-1:0] x [32];
        logic [XLEN-1:0] m [32];
        logic [XLEN-1:0] ins;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        for (int k = 0; k < 32; k++) begin
            x[k] = '0;
            m[k] = '0;
        end
        for (int pc = 0; pc < prog_len; pc++) begin
            ins   = prog[pc];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            a     = x[ins[19:15]];
            b     = (ins[6:0] == OPC_OP) ? x[ins[24:20]] : imm_i;
            case (ins[14:12])
                F3_ADD:  res = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
                F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F3_XOR:  res = a ^ b;
                F3_OR:   res = a | b;
                F3_AND:  res = a & b;
                default: res = '0;
            endcase
            case (ins[6:0])
                OPC_OP, OPC_OP_IMM: x[ins[11:7]] = res;
                OPC_LOAD: begin
                    addr         = a + imm_i;
                    x[ins[11:7]] = m[addr[DMEM_ADDR_W+1:2]];
                end
                OPC_STORE: begin
                    addr                     = a + imm_s;
                    m[addr[DMEM_ADDR_W+1:2]] = x[ins[24:20]];
                end
                default: ;
            endcase
            x[0] = '0;  // Hardwired zero
        end
        return x[idx];
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "register mismatch");
        end
    endtask

    // Readback over the debug port, one register every two cycles
    initial begin
        i_dbg_addr = '0;
        forever begin
            @(check_start);
            for (int r = 0; r < 32; r++) begin
                @(posedge clk);
                i_dbg_addr <= REG_ADDR_W'(r);
                @(posedge clk);  // Registered read
                @(negedge clk);
                check_value($sformatf("x%0d", r), o_dbg_data, model_reg(r));
            end
            -> check_done;
        end
    end

    task automatic reset_core();
        @(posedge clk);
        i_rst <= 1'b1;
        i_en  <= 1'b0;
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;
    endtask

    task automatic load_program();
        for (int k = 0; k < prog_len; k++) begin
            @(posedge clk);
            i_imem_we   <= 1'b1;
            i_imem_addr <= IMEM_ADDR_W'(k);
            i_imem_data <= prog[k];
        end
        @(posedge clk);
        i_imem_we <= 1'b0;
    endtask

    // Runs with i_en low for pause_len cycles starting at pause_at
    task automatic run_program(input int pause_at, input int pause_len);
        int run_len;
        run_len = prog_len + 10;  // Fill and drain margin
        for (int k = 0; k < prog_len; k++) begin
            if (prog[k][6:0] == OPC_LOAD) begin
                run_len++;  // At most one bubble per load
            end
        end
        reset_core();
        load_program();
        for (int c = 0; c < run_len + pause_len; c++) begin
            @(posedge clk);
            i_en <= (c < pause_at) || (c >= pause_at + pause_len);
        end
        @(posedge clk);
        i_en <= 1'b0;
        -> check_start;
        @(check_done);
    endtask

    task automatic build_alu_program();
        prog_len = 0;
        op_i(F3_ADD, 1, 0, 100);
        op_i(F3_ADD, 2, 0, -7);
        op_i(F3_ADD, 3, 0, 'h555);
        op_i(F3_ADD, 4, 0, -2048);
        op_i(F3_ADD, 5, 0, 2047);
        op_r(F7_BASE, F3_ADD, 6, 1, 2);
        op_r(F7_SUB, F3_ADD, 7, 2, 1);
        op_r(F7_BASE, F3_AND, 8, 3, 5);
        op_r(F7_BASE, F3_OR, 9, 3, 4);
        op_r(F7_BASE, F3_XOR, 10, 1, 3);
        op_r(F7_BASE, F3_SLT, 11, 2, 1);  // Negative below positive
        op_r(F7_BASE, F3_SLT, 12, 1, 2);
        op_r(F7_BASE, F3_SLT, 13, 4, 2);  // Both negative
        op_i(F3_AND, 14, 3, 'h0f0);
        op_i(F3_OR, 15, 2, 'h100);
        op_i(F3_XOR, 16, 1, -1);
        op_i(F3_SLT, 17, 2, -3);
        op_i(F3_SLT, 18, 2, -8);
        op_i(F3_SLT, 19, 1, 101);
        op_i(F3_ADD, 20, 4, -1);
    endtask

    // Each step reads the last two results
    task automatic build_chain_program();
        prog_len = 0;
        op_i(F3_ADD, 1, 0, 3);
        op_i(F3_ADD, 2, 0, 5);
        op_r(F7_BASE, F3_ADD, 3, 2, 1);
        op_r(F7_SUB, F3_ADD, 4, 3, 2);
        op_r(F7_BASE, F3_XOR, 5, 4, 3);
        op_r(F7_BASE, F3_OR, 6, 5, 4);
        op_r(F7_BASE, F3_AND, 7, 6, 5);
        op_r(F7_BASE, F3_SLT, 8, 7, 6);
        op_r(F7_BASE, F3_ADD, 9, 8, 7);
        op_i(F3_ADD, 0, 9, 77);  // Must not stick
        op_r(F7_BASE, F3_ADD, 10, 0, 9);
        op_i(F3_ADD, 11, 10, -1);
    endtask

    task automatic build_mem_program();
        prog_len = 0;
        op_i(F3_ADD, 1, 0, 'h123);
        op_i(F3_ADD, 2, 0, -300);
        op_i(F3_ADD, 3, 0, 16);
        store_word(1, 3, 0);
        store_word(2, 3, 4);
        store_word(1, 0, 60);
        load_word(4, 3, 0);
        op_r(F7_BASE, F3_ADD, 5, 4, 2);  // Load-use
        load_word(6, 3, 4);
        op_i(F3_ADD, 7, 6, 1);
        load_word(8, 0, 60);
        store_word(8, 3, -4);  // Loaded value stored straight away
        load_word(9, 0, 12);
        load_word(10, 3, 8);
        op_r(F7_BASE, F3_OR, 11, 10, 9);
    endtask

    function automatic logic [2:0] funct3_pick(input logic [2:0] sel);
        case (sel)
            3'd1, 3'd6: return F3_SLT;
            3'd2, 3'd7: return F3_XOR;
            3'd3:       return F3_OR;
            3'd4:       return F3_AND;
            default:    return F3_ADD;
        endcase
    endfunction

    // Small register set so results get reused often
    task automatic build_random_program();
        logic [31:0] r;
        logic [2:0]  f3;
        prog_len = 0;
        for (int k = 0; k < 50; k++) begin
            r  = $random(seed);
            f3 = funct3_pick(r[11:9]);
            case (r[14:12])
                3'd0, 3'd1: op_r((r[15] && f3 == F3_ADD) ? F7_SUB : F7_BASE, f3,
                                 r[2:0], r[5:3], r[8:6]);
                3'd2, 3'd3, 3'd4: op_i(f3, r[2:0], r[5:3], $signed(r[31:20]));
                3'd5: load_word(r[2:0], 0, {r[24:20], 2'b00});
                3'd6: store_word(r[8:6], 0, {r[24:20], 2'b00});
                default: op_i(F3_ADD, r[2:0], 0, $signed(r[31:20]));
            endcase
        end
    endtask

    initial begin
        seed        = 32'h7d93_6217;
        i_rst       = 1'b0;
        i_en        = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        prog_len    = 0;

        run_program(0, 0);  // Empty program, reset values only
        build_alu_program();
        run_program(0, 0);
        build_chain_program();
        run_program(0, 0);
        build_mem_program();
        run_program(0, 0);
        build_random_program();
        run_program(0, 0);
        build_random_program();
        run_program(20, 6);  // Core frozen mid-run

        $display("Verification passed");
        $finish;
    end

endmodule
